// File: common/pce_video_defines.svh
// Constants for the video expander and the bridge settings block.
// Include wherever a count, delay, threshold or bridge address is needed.

`ifndef PCE_VIDEO_DEFINES_SVH
`define PCE_VIDEO_DEFINES_SVH

// core reset hold after a reset command, kept short for simulation
`define PCE_RESET_DELAY_CYCLES 64

// expected line width per dot mode
`define PCE_LINE_WIDTH_NARROW 352
`define PCE_LINE_WIDTH_WIDE 512

// expected lines per frame
`define PCE_LINE_COUNT_FULL 240
`define PCE_LINE_COUNT_OVERSCAN 224

// border and hsync timing
`define PCE_BORDER_HOLD 4
`define PCE_HS_DELAY 6
`define PCE_BORDER_PIXEL_LIMIT 24
`define PCE_BORDER_CYCLE_LIMIT 160

// widest-line thresholds for slot classification
`define PCE_SLOT_THRESH_WIDE 380
`define PCE_SLOT_THRESH_352 330
`define PCE_SLOT_THRESH_320 280

// bridge setting addresses
`define PCE_SETTING_ADDR_RESET 32'h0000_0050
`define PCE_SETTING_ADDR_OVERSCAN 32'h0000_0200

`endif

// File: common/pce_video_pkg.sv
// Shared types for the video expander.
// Referenced by scoped name from the top level and the video blocks.

package pce_video_pkg;

  // line mode reported to the scaler in the slot word
  typedef enum logic [1:0] {
    slot_256 = 2'd0,
    slot_320 = 2'd1,
    slot_352 = 2'd2
  } video_slot_e;

  // dot clock divider code from the video source
  typedef enum logic [1:0] {
    dot_256 = 2'd0,
    dot_352 = 2'd1,
    dot_512 = 2'd2
  } dot_mode_e;

  // pixels or cycles within one line
  typedef logic [9:0] pixel_count_t;

  // lines within one frame
  typedef logic [8:0] line_count_t;

  // packed colour, red in the top byte
  typedef logic [23:0] rgb_t;

endpackage

// File: logic/settings_regs.sv
// Bridge settings block.
// Decodes single-cycle bridge writes into the overscan setting and a
// reset command, and holds core_reset high while the reset delay runs.

`timescale 1ns/1ps

`include "pce_video_defines.svh"

module settings_regs (
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  logic        bridge_wr,
  input  logic [31:0] bridge_addr,
  input  logic [31:0] bridge_wr_data,
  output logic        overscan_enable,
  output logic        core_reset
);

  localparam int delay_bits = $clog2(`PCE_RESET_DELAY_CYCLES + 1);

  typedef enum logic [1:0] {
    cmd_none,
    cmd_reset,
    cmd_overscan
  } setting_addr_e;

  setting_addr_e         cmd;
  logic [delay_bits-1:0] reset_delay;

  // address decode, only while the write strobe is up
  always_comb begin
    cmd = cmd_none;
    if (bridge_wr) begin
      case (bridge_addr)
        `PCE_SETTING_ADDR_RESET:    cmd = cmd_reset;
        `PCE_SETTING_ADDR_OVERSCAN: cmd = cmd_overscan;
        default:                    cmd = cmd_none;
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      overscan_enable <= 1'b0;
      reset_delay     <= '0;
    end else begin
      if (cmd == cmd_overscan) begin
        overscan_enable <= bridge_wr_data[0];
      end
      // a new command restarts the count
      if (cmd == cmd_reset) begin
        reset_delay <= delay_bits'(`PCE_RESET_DELAY_CYCLES);
      end else if (reset_delay != '0) begin
        reset_delay <= reset_delay - 1'b1;
      end
    end
  end

  assign core_reset = reset_delay != '0;

endmodule

// File: video/line_tracker.sv
// Line and frame position tracking for the source video.
// Counts pixels, cycles and lines from the source sync edges, stretches
// the border input and times the delayed hsync pulse.

`timescale 1ns/1ps

`include "pce_video_defines.svh"

module line_tracker (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  input  logic                        src_hblank,
  input  logic                        src_vblank,
  input  logic                        src_hsync,
  input  logic                        src_vsync,
  input  logic                        src_border,
  output pce_video_pkg::pixel_count_t pixel_count,
  output pce_video_pkg::pixel_count_t pixel_cycle_count,
  output pce_video_pkg::line_count_t  line_count,
  output logic                        line_started,
  output logic                        frame_started,
  output logic                        border_active,
  output logic                        hs_pulse
);

  localparam int border_bits = $clog2(`PCE_BORDER_HOLD + 1);
  localparam int hs_bits     = $clog2(`PCE_HS_DELAY + 1);

  logic                   hs_prev;
  logic                   vs_prev;
  logic                   hs_rise;
  logic                   vs_fall;
  logic                   src_de;
  logic [border_bits-1:0] border_cnt;
  logic [hs_bits-1:0]     hs_cnt;

  assign hs_rise       = src_hsync & ~hs_prev;
  assign vs_fall       = ~src_vsync & vs_prev;
  assign border_active = border_cnt != '0;
  assign src_de        = ~src_hblank & ~src_vblank & ~border_active;
  assign hs_pulse      = hs_cnt == hs_bits'(1);

  ////////////////////////////////////////////////////////////
  // sync history, border hold and hsync delay

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev    <= 1'b0;
      vs_prev    <= 1'b0;
      border_cnt <= '0;
      hs_cnt     <= '0;
    end else begin
      hs_prev <= src_hsync;
      vs_prev <= src_vsync;
      // border falls a few pixels early at the source
      if (src_border) begin
        border_cnt <= border_bits'(`PCE_BORDER_HOLD);
      end else if (border_active) begin
        border_cnt <= border_cnt - 1'b1;
      end
      // rise cycle itself is the first step of the delay
      if (hs_rise) begin
        hs_cnt <= hs_bits'(`PCE_HS_DELAY - 1);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pixel and line counters

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pixel_count       <= '0;
      pixel_cycle_count <= '0;
      line_count        <= '0;
      line_started      <= 1'b0;
      frame_started     <= 1'b0;
    end else begin
      // raw cycles since hsync, drawn or not
      if (pixel_cycle_count != '1) begin
        pixel_cycle_count <= pixel_cycle_count + 1'b1;
      end
      if (hs_rise) begin
        pixel_count       <= '0;
        pixel_cycle_count <= '0;
        line_started      <= 1'b0;
      end else if (src_de || line_started) begin
        if (pixel_count != '1) begin
          pixel_count <= pixel_count + 1'b1;
        end
        line_started <= 1'b1;
      end
      if (vs_fall) begin
        line_count <= '0;
      end else if (hs_rise && frame_started) begin
        line_count <= line_count + 1'b1;
      end
      if (vs_fall) begin
        frame_started <= 1'b0;
      end else if (!hs_rise && src_de) begin
        frame_started <= 1'b1;
      end
    end
  end

endmodule

// File: video/mode_detect.sv
// Video mode detection.
// Measures the widest unblanked line of each frame and classifies it
// into the slot reported to the scaler at the next vsync fall.

`timescale 1ns/1ps

`include "pce_video_defines.svh"

module mode_detect (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  logic                       src_hblank,
  input  logic                       src_vblank,
  input  logic                       src_hsync,
  input  logic                       src_vsync,
  output pce_video_pkg::video_slot_e video_slot
);

  logic                        hs_prev;
  logic                        vs_prev;
  pce_video_pkg::pixel_count_t line_cnt;
  pce_video_pkg::pixel_count_t line_max;
  pce_video_pkg::video_slot_e  slot_next;

  // widest line against the thresholds, widest modes fold into 256
  always_comb begin
    if (line_max > `PCE_SLOT_THRESH_WIDE) begin
      slot_next = pce_video_pkg::slot_256;
    end else if (line_max > `PCE_SLOT_THRESH_352) begin
      slot_next = pce_video_pkg::slot_352;
    end else if (line_max > `PCE_SLOT_THRESH_320) begin
      slot_next = pce_video_pkg::slot_320;
    end else begin
      slot_next = pce_video_pkg::slot_256;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev    <= 1'b0;
      vs_prev    <= 1'b0;
      line_cnt   <= '0;
      line_max   <= '0;
      video_slot <= pce_video_pkg::slot_256;
    end else begin
      hs_prev <= src_hsync;
      vs_prev <= src_vsync;
      if (src_hsync && !hs_prev) begin
        line_cnt <= '0;
      end else if (!src_hblank && !src_vblank && line_cnt != '1) begin
        line_cnt <= line_cnt + 1'b1;
      end
      // frame end wins over a line end in the same cycle
      if (!src_vsync && vs_prev) begin
        video_slot <= slot_next;
        line_max   <= '0;
      end else if (src_hsync && !hs_prev && line_cnt > line_max) begin
        line_max <= line_cnt;
      end
    end
  end

endmodule

// File: video/video_framer.sv
// Scaler-facing video outputs.
// Pads data-enable out to the expected line width and line count, passes
// source colour through, and places the slot word after each line.

`timescale 1ns/1ps

`include "pce_video_defines.svh"

module video_framer (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  input  logic                        src_hblank,
  input  logic                        src_vblank,
  input  logic                        src_vsync,
  input  pce_video_pkg::rgb_t         src_rgb,
  input  pce_video_pkg::dot_mode_e    src_dot_mode,
  input  logic                        overscan_enable,
  input  pce_video_pkg::pixel_count_t pixel_count,
  input  pce_video_pkg::pixel_count_t pixel_cycle_count,
  input  pce_video_pkg::line_count_t  line_count,
  input  logic                        line_started,
  input  logic                        frame_started,
  input  logic                        border_active,
  input  logic                        hs_pulse,
  input  pce_video_pkg::video_slot_e  video_slot,
  output pce_video_pkg::rgb_t         video_rgb,
  output logic                        video_de,
  output logic                        video_hs,
  output logic                        video_vs
);

  pce_video_pkg::pixel_count_t expected_width;
  pce_video_pkg::line_count_t  expected_lines;
  pce_video_pkg::rgb_t         slot_word;
  logic                        src_de;
  logic                        pad_hblank;
  logic                        pad_vblank;
  logic                        pad_border;
  logic                        vs_prev;
  logic                        de_prev;

  // 256 is pixel doubled, so it shares the 512 width
  assign expected_width = (src_dot_mode == pce_video_pkg::dot_352) ?
                          pce_video_pkg::pixel_count_t'(`PCE_LINE_WIDTH_NARROW) :
                          pce_video_pkg::pixel_count_t'(`PCE_LINE_WIDTH_WIDE);
  assign expected_lines = overscan_enable ?
                          pce_video_pkg::line_count_t'(`PCE_LINE_COUNT_OVERSCAN) :
                          pce_video_pkg::line_count_t'(`PCE_LINE_COUNT_FULL);

  assign src_de     = ~src_hblank & ~src_vblank & ~border_active;
  // blanks only take effect once the line or frame is long enough
  assign pad_hblank = src_hblank & ~(line_started & (pixel_count < expected_width));
  assign pad_vblank = (src_vblank & ~(frame_started & (line_count < `PCE_LINE_COUNT_FULL)))
                    | src_vsync;
  assign pad_border = border_active & (pixel_count < `PCE_BORDER_PIXEL_LIMIT)
                    & (pixel_cycle_count < `PCE_BORDER_CYCLE_LIMIT);

  assign video_de = src_de | (~pad_hblank & ~pad_vblank & ~pad_border
                    & (pixel_count < expected_width) & (line_count < expected_lines));

  // end of line word for the scaler
  assign slot_word = {8'h00, video_slot, overscan_enable, 13'h0000};

  always_comb begin
    if (src_de) begin
      video_rgb = src_rgb;
    end else if (de_prev && !video_de) begin
      video_rgb = slot_word;
    end else begin
      video_rgb = '0;
    end
  end

  assign video_vs = src_vsync & ~vs_prev;
  assign video_hs = hs_pulse;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs_prev <= 1'b0;
      de_prev <= 1'b0;
    end else begin
      vs_prev <= src_vsync;
      de_prev <= video_de;
    end
  end

endmodule

// File: logic/pce_video_top.sv
// Top level of the video expander.
// Connects the bridge settings block to the line tracker, mode detector
// and framer that turn raw source video into scaler-facing signals.

`timescale 1ns/1ps

module pce_video_top (
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  logic                     bridge_wr,
  input  logic [31:0]              bridge_addr,
  input  logic [31:0]              bridge_wr_data,
  input  logic                     src_hblank,
  input  logic                     src_vblank,
  input  logic                     src_hsync,
  input  logic                     src_vsync,
  input  logic                     src_border,
  input  pce_video_pkg::rgb_t      src_rgb,
  input  pce_video_pkg::dot_mode_e src_dot_mode,
  output logic                     core_reset,
  output pce_video_pkg::rgb_t      video_rgb,
  output logic                     video_de,
  output logic                     video_hs,
  output logic                     video_vs
);

  logic                        overscan_enable;
  pce_video_pkg::pixel_count_t pixel_count;
  pce_video_pkg::pixel_count_t pixel_cycle_count;
  pce_video_pkg::line_count_t  line_count;
  logic                        line_started;
  logic                        frame_started;
  logic                        border_active;
  logic                        hs_pulse;
  pce_video_pkg::video_slot_e  video_slot;

  ////////////////////////////////////////////////////////////
  // bridge settings

  settings_regs settings_regs_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .overscan_enable(overscan_enable),
    .core_reset     (core_reset)
  );

  ////////////////////////////////////////////////////////////
  // video path

  line_tracker line_tracker_inst (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .src_hblank       (src_hblank),
    .src_vblank       (src_vblank),
    .src_hsync        (src_hsync),
    .src_vsync        (src_vsync),
    .src_border       (src_border),
    .pixel_count      (pixel_count),
    .pixel_cycle_count(pixel_cycle_count),
    .line_count       (line_count),
    .line_started     (line_started),
    .frame_started    (frame_started),
    .border_active    (border_active),
    .hs_pulse         (hs_pulse)
  );

  mode_detect mode_detect_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .src_hblank     (src_hblank),
    .src_vblank     (src_vblank),
    .src_hsync      (src_hsync),
    .src_vsync      (src_vsync),
    .video_slot     (video_slot)
  );

  video_framer video_framer_inst (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .src_hblank       (src_hblank),
    .src_vblank       (src_vblank),
    .src_vsync        (src_vsync),
    .src_rgb          (src_rgb),
    .src_dot_mode     (src_dot_mode),
    .overscan_enable  (overscan_enable),
    .pixel_count      (pixel_count),
    .pixel_cycle_count(pixel_cycle_count),
    .line_count       (line_count),
    .line_started     (line_started),
    .frame_started    (frame_started),
    .border_active    (border_active),
    .hs_pulse         (hs_pulse),
    .video_slot       (video_slot),
    .video_rgb        (video_rgb),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs)
  );

endmodule

// File: verif/pce_video_checker.sv
// Concurrent checks on the top-level outputs of the video expander.
// Bound into pce_video_top, so it needs no instance in the testbench.

`timescale 1ns/1ps

module pce_video_checker (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic core_reset,
  input logic video_hs,
  input logic video_vs
);

  // both syncs are single-cycle pulses
  vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else $error("video_vs stayed high for two cycles");

  hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else $error("video_hs stayed high for two cycles");

  reset_quiet: assert property (@(posedge clk_74a) !pll_core_locked |-> !core_reset)
    else $error("core_reset high while pll_core_locked is low");

endmodule

bind pce_video_top pce_video_checker pce_video_checker_inst (.*);

// File: verif/tb_pce_video.sv
// Testbench for the video expander top level.
// Drives LFSR-generated frames and bridge writes, and compares every cycle
// of the outputs with a model of the framing rules.

`timescale 1ns/1ps

`include "pce_video_defines.svh"

module tb_pce_video;

  localparam int line_len    = 640;
  localparam int act_start   = 48;
  localparam int frame_lines = 254;
  localparam int num_frames  = 4;

  logic                     clk_74a;
  logic                     pll_core_locked;
  logic                     bridge_wr;
  logic [31:0]              bridge_addr;
  logic [31:0]              bridge_wr_data;
  logic                     src_hblank;
  logic                     src_vblank;
  logic                     src_hsync;
  logic                     src_vsync;
  logic                     src_border;
  pce_video_pkg::rgb_t      src_rgb;
  pce_video_pkg::dot_mode_e src_dot_mode;
  logic                     core_reset;
  pce_video_pkg::rgb_t      video_rgb;
  logic                     video_de;
  logic                     video_hs;
  logic                     video_vs;

  logic [15:0] lfsr;
  int          errors [6];
  string       test_names [6];
  int          total_errors;

  // model and loop state
  int   f, ln, c, idx, r, w, ew, el, ov, dm, n_active, cap, bend;
  int   cur_max, prev_max, line_de, de_lines, rst_len, t, de_len;
  logic de_exp, prev_de_exp, src_de_exp, vs_exp, hs_exp, border_exp;
  logic [1:0] slot_exp;
  pce_video_pkg::rgb_t rgb_exp;

  pce_video_top pce_video_top_inst (.*);

  always #10 clk_74a = ~clk_74a;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // slot from widest unblanked line
  function automatic logic [1:0] classify(input int width);
    if (width > `PCE_SLOT_THRESH_WIDE) begin
      return 2'd0;
    end else if (width > `PCE_SLOT_THRESH_352) begin
      return 2'd2;
    end else if (width > `PCE_SLOT_THRESH_320) begin
      return 2'd1;
    end
    return 2'd0;
  endfunction

  task automatic report_mismatch(input int id, input logic [31:0] expected,
                                 input logic [31:0] actual);
    if (errors[id] < 5) begin
      $display("FAIL %s expected %h actual %h", test_names[id], expected, actual);
    end
    errors[id]++;
  endtask

  initial begin
    #30_000_000;
    $display("simulation ran past its time limit");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    test_names = '{"reset_cmd", "vsync_pulse", "hsync_pulse", "pass_through",
                   "padding", "mode_word"};
    errors = '{default: 0};
    lfsr = 16'd83;
    clk_74a = 1'b0;
    pll_core_locked = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    src_hblank = 1'b1;
    src_vblank = 1'b1;
    src_hsync = 1'b0;
    src_vsync = 1'b0;
    src_border = 1'b0;
    src_rgb = '0;
    src_dot_mode = pce_video_pkg::dot_256;
    prev_de_exp = 1'b0;
    prev_max = 0;
    repeat (16) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    repeat (4) @(negedge clk_74a);

    ////////////////////////////////////////////////////////////
    // reset command

    bridge_wr = 1'b1;
    bridge_addr = `PCE_SETTING_ADDR_RESET;
    bridge_wr_data = 32'h1;
    #9;
    if (core_reset !== 1'b0) report_mismatch(0, 0, core_reset);
    rst_len = 0;
    t = 0;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    #9;
    while (core_reset === 1'b1 && t < 300) begin
      rst_len++;
      t++;
      @(negedge clk_74a);
      #9;
    end
    if (t >= 300) begin
      $display("core_reset did not fall within 300 cycles");
      errors[0]++;
    end
    if (rst_len != `PCE_RESET_DELAY_CYCLES) report_mismatch(0, 64, rst_len);
    $display("test %s: %0d errors", test_names[0], errors[0]);

    ////////////////////////////////////////////////////////////
    // frames

    for (f = 0; f < num_frames; f++) begin
      take_bits(1, ov);
      take_bits(2, dm);
      ew = (dm == 1) ? `PCE_LINE_WIDTH_NARROW : `PCE_LINE_WIDTH_WIDE;
      el = ov ? `PCE_LINE_COUNT_OVERSCAN : `PCE_LINE_COUNT_FULL;
      take_bits(8, r);
      n_active = 150 + r % (el - 150);
      take_bits(9, r);
      cap = 200 + r % (ew - 200);
      // border runs a few pixels into the active region
      take_bits(3, r);
      bend = act_start + r;
      slot_exp = classify(prev_max);
      cur_max = 0;
      de_lines = 0;
      for (ln = 0; ln < frame_lines; ln++) begin
        // idx counts lines from the first active one
        idx = ln - 4;
        take_bits(5, r);
        w = cap - r;
        if (idx >= 0 && idx < n_active && w > cur_max) cur_max = w;
        line_de = 0;
        for (c = 0; c < line_len; c++) begin
          @(negedge clk_74a);
          src_hsync = c < 4;
          src_vsync = ln < 2;
          src_vblank = !(idx >= 0 && idx < n_active);
          src_hblank = !(c >= act_start && c < act_start + w);
          src_border = c >= 20 && c < bend;
          case (dm)
            0: src_dot_mode = pce_video_pkg::dot_256;
            1: src_dot_mode = pce_video_pkg::dot_352;
            default: src_dot_mode = pce_video_pkg::dot_512;
          endcase
          bridge_wr = ln == 0 && c == 1;
          bridge_addr = `PCE_SETTING_ADDR_OVERSCAN;
          bridge_wr_data = ov;
          // border is seen a cycle late and held after the source drops it
          border_exp = c > 20 && c < bend + `PCE_BORDER_HOLD;
          src_de_exp = !src_hblank && !src_vblank && !border_exp;
          if (src_de_exp) begin
            take_bits(24, r);
            src_rgb = r[23:0];
          end else begin
            src_rgb = '0;
          end
          // active lines pad to full width, padded lines follow hblank
          if (idx >= 0 && idx < el) begin
            if (idx < n_active) begin
              de_exp = c >= bend + `PCE_BORDER_HOLD && c < bend + `PCE_BORDER_HOLD + ew;
            end else begin
              de_exp = !src_hblank && !border_exp;
            end
          end else begin
            de_exp = 1'b0;
          end
          if (src_de_exp) begin
            rgb_exp = src_rgb;
          end else if (prev_de_exp && !de_exp) begin
            rgb_exp = {8'h00, slot_exp, ov[0], 13'h0000};
          end else begin
            rgb_exp = '0;
          end
          vs_exp = ln == 0 && c == 0;
          hs_exp = c == 5;
          #9;
          if (video_vs !== vs_exp) report_mismatch(1, vs_exp, video_vs);
          if (video_hs !== hs_exp) report_mismatch(2, hs_exp, video_hs);
          if (src_de_exp && (video_de !== 1'b1 || video_rgb !== src_rgb)) begin
            report_mismatch(3, src_rgb, video_rgb);
          end
          if (video_de !== de_exp) report_mismatch(4, de_exp, video_de);
          if (!src_de_exp && video_rgb !== rgb_exp) report_mismatch(5, rgb_exp, video_rgb);
          prev_de_exp = de_exp;
          if (video_de === 1'b1) line_de++;
        end
        if (line_de > 0) de_lines++;
        if (idx >= 0 && idx < el) begin
          if (idx < n_active) begin
            de_len = ew;
          end else begin
            de_len = act_start + w - bend - `PCE_BORDER_HOLD;
          end
          if (line_de != de_len) report_mismatch(4, de_len, line_de);
        end
      end
      if (f > 0 && de_lines != el) report_mismatch(4, el, de_lines);
      prev_max = cur_max;
    end

    for (int i = 1; i < 6; i++) begin
      $display("test %s: %0d errors", test_names[i], errors[i]);
    end
    total_errors = 0;
    for (int i = 0; i < 6; i++) begin
      total_errors += errors[i];
    end
    $display("tests run: 6, errors: %0d", total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+common
common/pce_video_pkg.sv
logic/settings_regs.sv
video/line_tracker.sv
video/mode_detect.sv
video/video_framer.sv
logic/pce_video_top.sv
verif/pce_video_checker.sv
verif/tb_pce_video.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video expander testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_pce_video -o sim_pce_video
./obj_dir/sim_pce_video > sim.log
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log
